// File: list.f
logic/rv_pkg.sv
logic/decode_if.sv
logic/pc_unit.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/execute_unit.sv
logic/mem_wb_unit.sv
logic/core_top.sv
tb/core_tb.sv

// File: logic/alu.sv
// ========================================
// rv32i alu
// ========================================

`timescale 1ns/100ps

module alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    logic [$clog2(XLEN)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign shamt       = b[$clog2(XLEN)-1:0];   // low five bits only
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);  // keeps sign bit
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// File: logic/core_top.sv
// ========================================
// rv32i single cycle core
// ========================================

`timescale 1ns/100ps

module core_top import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h8000_0000
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      imem_rdata,
    input  word_t      dmem_rdata,
    output word_t      imem_addr,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    output logic [3:0] dmem_wmask,
    output logic       dmem_we,
    output logic       wb_en,
    output reg_idx_t   wb_rd,
    output word_t      wb_data
);

    word_t pc;
    word_t snpc;
    word_t jump_target;
    logic  jump_en;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    logic  rd_we;
    word_t rd_wdata;

    decode_if dec_bus ();

    pc_unit #(
        .RESET_PC(RESET_PC)
    ) u_pc_unit (
        .clk        (clk),
        .reset      (reset),
        .jump_en    (jump_en),
        .jump_target(jump_target),
        .pc         (pc),
        .snpc       (snpc)
    );

    inst_decoder u_inst_decoder (
        .inst(imem_rdata),
        .dec (dec_bus.decoder)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .we    (rd_we),
        .waddr (dec_bus.rd),
        .wdata (rd_wdata),
        .raddr1(dec_bus.rs1),
        .raddr2(dec_bus.rs2),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

    execute_unit u_execute_unit (
        .dec        (dec_bus.exec),
        .pc         (pc),
        .snpc       (snpc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .jump_target(jump_target),
        .jump_en    (jump_en)
    );

    mem_wb_unit u_mem_wb_unit (
        .reset     (reset),
        .dec       (dec_bus.wb),
        .snpc      (snpc),
        .alu_result(alu_result),
        .rs2_data  (rs2_data),
        .dmem_rdata(dmem_rdata),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_wmask(dmem_wmask),
        .dmem_we   (dmem_we),
        .rd_we     (rd_we),
        .rd_wdata  (rd_wdata)
    );

    assign imem_addr = pc;    // fetch straight from the pc register

    // register write port made visible for checking
    assign wb_en   = rd_we;
    assign wb_rd   = dec_bus.rd;
    assign wb_data = rd_wdata;

endmodule

// File: logic/decode_if.sv
// ========================================
// decoded instruction bus
// ========================================

`timescale 1ns/100ps

interface decode_if import rv_pkg::*; ();

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm;       // already sign extended
    inst_fmt_t  fmt;
    alu_op_t    alu_op;

    modport decoder (
        output opcode, funct3, rd, rs1, rs2, imm, fmt, alu_op
    );

    modport exec (
        input opcode, funct3, rd, rs1, rs2, imm, fmt, alu_op
    );

    // writeback only needs to know what kind of result goes where
    modport wb (
        input opcode, funct3, rd
    );

endinterface

// File: logic/execute_unit.sv
// ========================================
// execute and branch resolve
// ========================================

`timescale 1ns/100ps

module execute_unit import rv_pkg::*; (
    decode_if.exec dec,
    input  word_t  pc,
    input  word_t  snpc,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    output word_t  alu_result,
    output word_t  jump_target,
    output logic   jump_en
);

    word_t alu_a;
    word_t alu_b;

    alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (dec.alu_op),
        .result(alu_result)
    );

    // operand select by format
    always_comb begin
        case (dec.fmt)
            FMT_R: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            FMT_I, FMT_S: begin
                alu_a = rs1_data;   // includes load/store address
                alu_b = dec.imm;
            end
            FMT_U: begin
                alu_a = (dec.opcode == OP_LUI) ? word_t'(0) : pc;
                alu_b = dec.imm;
            end
            FMT_J, FMT_B: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    // jump resolution with pc+4 as fallthrough
    always_comb begin
        jump_target = snpc;
        jump_en     = 1'b0;
        if (dec.opcode == OP_JAL) begin
            jump_target = alu_result;
            jump_en     = 1'b1;
        end else if (dec.opcode == OP_JALR) begin
            jump_target = {alu_result[XLEN-1:1], 1'b0};
            jump_en     = 1'b1;
        end else if (dec.opcode == OP_BRANCH) begin
            jump_target = alu_result;   // pc + imm
            case (dec.funct3)
                F3_BEQ:  jump_en = (rs1_data == rs2_data);
                F3_BNE:  jump_en = (rs1_data != rs2_data);
                F3_BLT:  jump_en = ($signed(rs1_data) < $signed(rs2_data));
                F3_BGE:  jump_en = ($signed(rs1_data) >= $signed(rs2_data));
                F3_BLTU: jump_en = (rs1_data < rs2_data);
                F3_BGEU: jump_en = (rs1_data >= rs2_data);
                default: jump_en = 1'b0;
            endcase
        end
    end

endmodule

// File: logic/inst_decoder.sv
// ========================================
// instruction decoder
// ========================================

`timescale 1ns/100ps

module inst_decoder import rv_pkg::*; (
    input  word_t     inst,
    decode_if.decoder dec
);

    logic [6:0] funct7;
    opcode_t    opcode;

    assign opcode     = opcode_t'(inst[6:0]);
    assign funct7     = inst[31:25];
    assign dec.opcode = opcode;
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];

    // format from major opcode
    always_comb begin
        case (opcode)
            OP_REG:                    dec.fmt = FMT_R;
            OP_IMM, OP_LOAD, OP_JALR:  dec.fmt = FMT_I;
            OP_STORE:                  dec.fmt = FMT_S;
            OP_BRANCH:                 dec.fmt = FMT_B;
            OP_LUI, OP_AUIPC:          dec.fmt = FMT_U;
            OP_JAL:                    dec.fmt = FMT_J;
            default:                   dec.fmt = FMT_N;
        endcase
    end

    always_comb begin
        case (dec.fmt)
            FMT_I: dec.imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            FMT_S: dec.imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B: begin
                dec.imm = {{(XLEN-13){inst[31]}}, inst[31], inst[7],
                           inst[30:25], inst[11:8], 1'b0};
            end
            FMT_U: dec.imm = {inst[31:12], 12'b0};    // upper 20 bits
            FMT_J: begin
                dec.imm = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12],
                           inst[20], inst[30:21], 1'b0};
            end
            default: dec.imm = '0;
        endcase
    end

    // alu op only matters for the arithmetic opcodes
    // everything else adds (addresses, pc+imm, lui)
    always_comb begin
        dec.alu_op = ALU_ADD;
        if (opcode == OP_IMM || opcode == OP_REG) begin
            case (dec.funct3)
                3'b000: begin
                    if (dec.fmt == FMT_R && funct7 == 7'b0100000) begin
                        dec.alu_op = ALU_SUB;   // no subi in rv32i
                    end
                end
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // bit 30
                3'b110: dec.alu_op = ALU_OR;
                3'b111: dec.alu_op = ALU_AND;
                default: dec.alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

// File: logic/mem_wb_unit.sv
// ========================================
// load store and writeback
// ========================================

`timescale 1ns/100ps

module mem_wb_unit import rv_pkg::*; (
    input  logic       reset,
    decode_if.wb       dec,
    input  word_t      snpc,
    input  word_t      alu_result,
    input  word_t      rs2_data,
    input  word_t      dmem_rdata,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    output logic [3:0] dmem_wmask,
    output logic       dmem_we,
    output logic       rd_we,
    output word_t      rd_wdata
);

    word_t load_data;
    logic  wb_req;

    // store data goes out unshifted
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = (dec.opcode == OP_STORE) && !reset;

    always_comb begin
        case (dec.funct3)
            F3_BYTE: dmem_wmask = 4'b0001;
            F3_HALF: dmem_wmask = 4'b0011;
            F3_WORD: dmem_wmask = 4'b1111;
            default: dmem_wmask = 4'b0000;   // not a legal store width
        endcase
    end

    // load extension from the low lanes
    always_comb begin
        case (dec.funct3)
            F3_BYTE:   load_data = {{(XLEN-8){dmem_rdata[7]}}, dmem_rdata[7:0]};
            F3_HALF:   load_data = {{(XLEN-16){dmem_rdata[15]}}, dmem_rdata[15:0]};
            F3_WORD:   load_data = dmem_rdata;
            F3_BYTE_U: load_data = {{(XLEN-8){1'b0}}, dmem_rdata[7:0]};
            F3_HALF_U: load_data = {{(XLEN-16){1'b0}}, dmem_rdata[15:0]};
            default:   load_data = '0;
        endcase
    end

    // writeback source select
    always_comb begin
        wb_req   = 1'b1;
        rd_wdata = alu_result;
        case (dec.opcode)
            OP_JAL, OP_JALR: rd_wdata = snpc;    // link address
            OP_LOAD:         rd_wdata = load_data;
            OP_IMM, OP_REG, OP_LUI, OP_AUIPC: rd_wdata = alu_result;
            default: begin
                wb_req   = 1'b0;   // branch, store, unknown
                rd_wdata = '0;
            end
        endcase
    end

    // x0 filtering happens in the register file
    assign rd_we = wb_req && !reset;

    // a bad store funct3 from the decoder ends up here
    wmask_nonzero: assert final (!dmem_we || dmem_wmask != 4'b0000)
        else $error("store issued with empty byte mask");

endmodule

// File: logic/pc_unit.sv
// ========================================
// program counter
// ========================================

`timescale 1ns/100ps

module pc_unit import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t snpc
);

    word_t dnpc;

    assign snpc = pc + XLEN'(4);
    assign dnpc = jump_en ? jump_target : snpc;   // taken jump wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

    // jump targets come from execute, so misalignment shows up here first
    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// File: logic/reg_file.sv
// ========================================
// integer register file
// ========================================

`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin  // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == 5'd0) ? word_t'(0) : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? word_t'(0) : regs[raddr2];

    // writeback enable is produced in mem_wb_unit and must be quiet in reset
    no_write_in_reset: assert property (@(posedge clk) reset |-> !we)
        else $error("register write requested during reset");

endmodule

// File: logic/rv_pkg.sv
// ========================================
// rv32i shared types
// ========================================

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N   // unknown opcode
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // load/store width codes
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

// File: tb/core_tb.sv
// ========================================
// rv32i core testbench
// ========================================

`timescale 1ns/100ps

module core_tb import rv_pkg::*; ();

    localparam word_t RESET_PC = 32'h8000_0000;
    localparam int    MAX_ROWS = 64;
    localparam word_t NOP      = 32'h0000_0013;   // addi x0, x0, 0

    logic       clk;
    logic       reset;
    word_t      imem_rdata;
    word_t      dmem_rdata;
    word_t      imem_addr;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    logic [3:0] dmem_wmask;
    logic       dmem_we;
    logic       wb_en;
    reg_idx_t   wb_rd;
    word_t      wb_data;

    // program table, row n sits at RESET_PC + 4n
    word_t      prog      [MAX_ROWS];
    logic       exp_wb_en [MAX_ROWS];
    reg_idx_t   exp_rd    [MAX_ROWS];
    word_t      exp_data  [MAX_ROWS];
    logic       exp_we    [MAX_ROWS];
    word_t      exp_addr  [MAX_ROWS];
    logic [3:0] exp_mask  [MAX_ROWS];
    word_t      exp_wdata [MAX_ROWS];
    word_t      exp_next  [MAX_ROWS];
    int         n_rows = 0;

    word_t dmem [16];
    int    cycles      = 0;
    int    cycle_limit = 1000;
    int    pass_count  = 0;
    int    fail_count  = 0;
    int    row_errors  = 0;

    core_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_rdata(imem_rdata),
        .dmem_rdata(dmem_rdata),
        .imem_addr (imem_addr),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_wmask(dmem_wmask),
        .dmem_we   (dmem_we),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // data memory indexed by address bits 5:2
    assign dmem_rdata = dmem[dmem_addr[5:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int k = 0; k < 4; k++) begin
                if (dmem_wmask[k]) begin
                    dmem[dmem_addr[5:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: program still running after %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic word_t row_pc(int n);
        return RESET_PC + word_t'(4 * n);
    endfunction

    // instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic add_row(word_t inst, logic we_wb, reg_idx_t rd, word_t data, logic we_mem,
                           word_t addr, logic [3:0] mask, word_t wdata, int step);
        prog[n_rows]      = inst;
        exp_wb_en[n_rows] = we_wb;
        exp_rd[n_rows]    = rd;
        exp_data[n_rows]  = data;
        exp_we[n_rows]    = we_mem;
        exp_addr[n_rows]  = addr;
        exp_mask[n_rows]  = mask;
        exp_wdata[n_rows] = wdata;
        exp_next[n_rows]  = row_pc(n_rows) + word_t'(step);
        n_rows++;
    endtask

    task automatic add_wb(word_t inst, reg_idx_t rd, word_t data);
        add_row(inst, 1'b1, rd, data, 1'b0, '0, '0, '0, 4);
    endtask

    task automatic add_store(word_t inst, word_t addr, logic [3:0] mask, word_t wdata);
        add_row(inst, 1'b0, '0, '0, 1'b1, addr, mask, wdata, 4);
    endtask

    // row that a taken jump must step over
    task automatic add_skip();
        add_row(enc_i(12'h001, 5'd0, 3'b000, 5'd31, OP_IMM), 1'b0, '0, '0, 1'b0, '0, '0, '0, 4);
    endtask

    task automatic add_branch(word_t inst, logic taken);
        add_row(inst, 1'b0, '0, '0, 1'b0, '0, '0, '0, taken ? 8 : 4);
        if (taken) begin
            add_skip();
        end
    endtask

    task automatic build_program();
        word_t p;
        // x1 = -5 and x2 = 3 feed most of what follows
        add_wb(enc_i(12'hFFB, 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, 32'hFFFF_FFFB);
        add_wb(enc_i(12'h003, 5'd0, 3'b000, 5'd2, OP_IMM), 5'd2, 32'h0000_0003);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'hFFFF_FFFE);
        add_wb(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4), 5'd4, 32'h0000_0008);   // 3 - (-5)
        add_wb(enc_r(7'h00, 5'd2, 5'd2, 3'b001, 5'd5), 5'd5, 32'h0000_0018);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd6), 5'd6, 32'h0000_0001);   // signed less
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd7), 5'd7, 32'h0000_0000);   // unsigned not
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 5'd8, 32'hFFFF_FFF8);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd9), 5'd9, 32'h1FFF_FFFF);
        add_wb(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd10), 5'd10, 32'hFFFF_FFFF);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 5'd11, 32'hFFFF_FFFB);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 5'd12, 32'h0000_0003);
        add_wb(enc_i(12'd31, 5'd0, 3'b000, 5'd13, OP_IMM), 5'd13, 32'd31);
        add_wb(enc_r(7'h00, 5'd13, 5'd2, 3'b001, 5'd14), 5'd14, 32'h8000_0000);
        add_wb(enc_r(7'h20, 5'd13, 5'd14, 3'b101, 5'd15), 5'd15, 32'hFFFF_FFFF);
        add_wb(enc_i(12'h007, 5'd2, 3'b000, 5'd0, OP_IMM), 5'd0, 32'h0000_000A);  // to x0
        add_wb(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd16), 5'd16, 32'h0000_0003);
        add_wb(enc_i(12'h401, 5'd1, 3'b101, 5'd17, OP_IMM), 5'd17, 32'hFFFF_FFFD); // srai 1
        add_wb(enc_u(20'h12345, 5'd19, OP_LUI), 5'd19, 32'h1234_5000);
        add_wb(enc_u(20'h00001, 5'd20, OP_AUIPC), 5'd20, row_pc(n_rows) + 32'h0000_1000);
        p = row_pc(n_rows);
        add_row(enc_j(21'd8, 5'd21), 1'b1, 5'd21, p + 32'd4, 1'b0, '0, '0, '0, 8);
        add_skip();
        p = row_pc(n_rows);
        add_wb(enc_u(20'h00000, 5'd22, OP_AUIPC), 5'd22, p);
        // target two rows past the jalr, plus a stray bit 0
        add_row(enc_i(12'd13, 5'd22, 3'b000, 5'd23, OP_JALR), 1'b1, 5'd23, p + 32'd8,
                1'b0, '0, '0, '0, 8);
        add_skip();
        add_branch(enc_b(13'd8, 5'd1, 5'd2, F3_BEQ), 1'b0);
        add_branch(enc_b(13'd8, 5'd2, 5'd2, F3_BEQ), 1'b1);
        add_branch(enc_b(13'd8, 5'd2, 5'd2, F3_BNE), 1'b0);
        add_branch(enc_b(13'd8, 5'd1, 5'd2, F3_BNE), 1'b1);
        add_branch(enc_b(13'd8, 5'd2, 5'd1, F3_BLT), 1'b0);
        add_branch(enc_b(13'd8, 5'd1, 5'd2, F3_BLT), 1'b1);
        add_branch(enc_b(13'd8, 5'd1, 5'd2, F3_BGE), 1'b0);
        add_branch(enc_b(13'd8, 5'd2, 5'd1, F3_BGE), 1'b1);
        add_branch(enc_b(13'd8, 5'd1, 5'd2, F3_BLTU), 1'b0);   // -5 is huge unsigned
        add_branch(enc_b(13'd8, 5'd2, 5'd1, F3_BLTU), 1'b1);
        add_branch(enc_b(13'd8, 5'd2, 5'd1, F3_BGEU), 1'b0);
        add_branch(enc_b(13'd8, 5'd1, 5'd2, F3_BGEU), 1'b1);
        // word at 0x14 preloaded as C0DE8A85
        add_wb(enc_i(12'h011, 5'd2, F3_BYTE, 5'd24, OP_LOAD), 5'd24, 32'hFFFF_FF85);
        add_wb(enc_i(12'h011, 5'd2, F3_BYTE_U, 5'd25, OP_LOAD), 5'd25, 32'h0000_0085);
        add_wb(enc_i(12'h011, 5'd2, F3_HALF, 5'd26, OP_LOAD), 5'd26, 32'hFFFF_8A85);
        add_wb(enc_i(12'h011, 5'd2, F3_HALF_U, 5'd27, OP_LOAD), 5'd27, 32'h0000_8A85);
        add_wb(enc_i(12'h011, 5'd2, F3_WORD, 5'd28, OP_LOAD), 5'd28, 32'hC0DE_8A85);
        add_store(enc_s(12'h015, 5'd1, 5'd2, F3_BYTE), 32'h18, 4'h1, 32'hFFFF_FFFB);
        add_store(enc_s(12'h019, 5'd1, 5'd2, F3_HALF), 32'h1C, 4'h3, 32'hFFFF_FFFB);
        add_store(enc_s(12'h01D, 5'd1, 5'd2, F3_WORD), 32'h20, 4'hF, 32'hFFFF_FFFB);
        // read back shows only masked lanes changed
        add_wb(enc_i(12'h015, 5'd2, F3_WORD, 5'd29, OP_LOAD), 5'd29, 32'hC0DE_8AFB);
        add_wb(enc_i(12'h019, 5'd2, F3_WORD, 5'd30, OP_LOAD), 5'd30, 32'hC0DE_FFFB);
        add_wb(enc_i(12'h01D, 5'd2, F3_WORD, 5'd31, OP_LOAD), 5'd31, 32'hFFFF_FFFB);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic report_test(string what);
        if (row_errors == 0) begin
            pass_count++;
            $display("%s: pass", what);
        end else begin
            fail_count++;
            $display("%s: fail", what);
        end
        row_errors = 0;
    endtask

    task automatic check_row(int idx);
        check_word("imem_addr", imem_addr, row_pc(idx));
        check_bit("wb_en", wb_en, exp_wb_en[idx]);
        if (exp_wb_en[idx]) begin
            check_reg("wb_rd", wb_rd, exp_rd[idx]);
            check_word("wb_data", wb_data, exp_data[idx]);
        end
        check_bit("dmem_we", dmem_we, exp_we[idx]);
        if (exp_we[idx]) begin
            check_word("dmem_addr", dmem_addr, exp_addr[idx]);
            check_word("dmem_wmask", word_t'(dmem_wmask), word_t'(exp_mask[idx]));
            check_word("dmem_wdata", dmem_wdata, exp_wdata[idx]);
        end
        report_test($sformatf("row %0d at %h", idx, row_pc(idx)));
    endtask

    initial begin
        int idx;
        int nxt;
        for (int i = 0; i < 16; i++) begin
            dmem[i] = 32'hC0DE_8A80 + word_t'(i);
        end
        build_program();
        cycle_limit = n_rows + 20;
        reset      = 1'b1;
        imem_rdata = enc_i(12'h001, 5'd0, 3'b000, 5'd1, OP_IMM);   // write held off by reset
        #10;    // middle of the low phase before the first edge
        check_bit("wb_en", wb_en, 1'b0);
        @(posedge clk);
        imem_rdata <= enc_s(12'h010, 5'd1, 5'd2, F3_WORD);   // store held off by reset
        @(negedge clk);
        check_bit("dmem_we", dmem_we, 1'b0);
        report_test("reset");
        @(posedge clk);
        reset      <= 1'b0;
        imem_rdata <= prog[0];
        idx = 0;
        while (idx < n_rows) begin
            @(negedge clk);
            check_row(idx);
            nxt = int'((exp_next[idx] - RESET_PC) >> 2);
            @(posedge clk);
            imem_rdata <= (nxt < n_rows) ? prog[nxt] : NOP;
            idx = nxt;
        end
        @(negedge clk);
        check_word("imem_addr", imem_addr, row_pc(idx));
        report_test("final pc");
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
